/* hw/simd_alu_pkg.sv */
// Shared widths, vector types and control encodings for the packed-SIMD ALU.
// Design and testbench files refer to these by scoped names.
package simd_alu_pkg;

  // Operand and lane geometry
  localparam int XLEN     = 32;
  localparam int LANE8_W  = 8;
  localparam int LANE16_W = 16;

  typedef logic [XLEN-1:0]           word_t;
  // One bit per byte lane, both bytes of a halfword lane carry the same value
  typedef logic [XLEN/LANE8_W-1:0]   lane_mask_t;

  typedef enum logic [4:0] {
    OP_ADD,
    OP_SUB,
    OP_RADD,
    OP_URADD,
    OP_KADD,
    OP_UKADD,
    OP_KSUB,
    OP_UKSUB,
    OP_CMPEQ,
    OP_SCMPLT,
    OP_UCMPLT,
    OP_SMIN,
    OP_SMAX,
    OP_UMIN,
    OP_UMAX,
    OP_SRA,
    OP_SRL,
    OP_SLL
  } simd_op_e;

  typedef enum logic {
    LANES_8,
    LANES_16
  } lane_width_e;

  typedef enum logic [1:0] {
    ADD_WRAP,
    ADD_HALVE,
    ADD_SAT
  } add_mode_e;

  typedef enum logic [1:0] {
    CMP_EQ,
    CMP_LT,
    CMP_MIN,
    CMP_MAX
  } cmp_kind_e;

  typedef enum logic [1:0] {
    RES_ADD,
    RES_CMP,
    RES_MINMAX,
    RES_SHIFT
  } res_sel_e;

  // Clamp values for saturating add/sub
  localparam logic [7:0]  SAT_S8_MIN  = 8'h80;
  localparam logic [7:0]  SAT_S8_MAX  = 8'h7f;
  localparam logic [15:0] SAT_S16_MIN = 16'h8000;
  localparam logic [15:0] SAT_S16_MAX = 16'h7fff;
  localparam logic [7:0]  SAT_U8_MAX  = 8'hff;
  localparam logic [15:0] SAT_U16_MAX = 16'hffff;

endpackage

/* hw/simd_ctrl_if.sv */
// Decoded lane controls, driven by the op decoder and read by the
// adder, compare, shifter and result stage through their own modports.
interface simd_ctrl_if;

  simd_alu_pkg::lane_width_e lane_w;
  logic                      is_signed;
  logic                      is_sub;
  simd_alu_pkg::add_mode_e   add_mode;
  simd_alu_pkg::cmp_kind_e   cmp_kind;
  logic                      shift_left;
  logic                      shift_arith;
  simd_alu_pkg::res_sel_e    res_sel;

  modport dec (
    output lane_w, is_signed, is_sub, add_mode,
    output cmp_kind, shift_left, shift_arith, res_sel
  );

  modport adder  (input lane_w, is_signed, is_sub, add_mode);
  modport cmp    (input lane_w, is_signed, cmp_kind);
  modport shift  (input lane_w, shift_left, shift_arith);
  modport result (input res_sel, add_mode);

endinterface

/* hw/simd_op_decoder.sv */
// Operation decoder. Maps the op code and lane width onto the control
// bundle used by the datapath units; purely combinational.
module simd_op_decoder (
  input  simd_alu_pkg::simd_op_e    op_i,
  input  simd_alu_pkg::lane_width_e width_i,
  input  logic                      valid_i,
  simd_ctrl_if.dec                  ctrl
);

  logic op_legal;

  always_comb begin
    ctrl.lane_w      = width_i;
    ctrl.is_signed   = 1'b0;
    ctrl.is_sub      = 1'b0;
    ctrl.add_mode    = simd_alu_pkg::ADD_WRAP;
    ctrl.cmp_kind    = simd_alu_pkg::CMP_EQ;
    ctrl.shift_left  = 1'b0;
    ctrl.shift_arith = 1'b0;
    ctrl.res_sel     = simd_alu_pkg::RES_ADD;
    op_legal         = 1'b1;

    // Compares and min/max run the adder as a subtractor
    case (op_i)
      simd_alu_pkg::OP_ADD: ;
      simd_alu_pkg::OP_SUB: ctrl.is_sub = 1'b1;
      simd_alu_pkg::OP_RADD: begin
        ctrl.is_signed = 1'b1;
        ctrl.add_mode  = simd_alu_pkg::ADD_HALVE;
      end
      simd_alu_pkg::OP_URADD: ctrl.add_mode = simd_alu_pkg::ADD_HALVE;
      simd_alu_pkg::OP_KADD,
      simd_alu_pkg::OP_UKADD,
      simd_alu_pkg::OP_KSUB,
      simd_alu_pkg::OP_UKSUB: begin
        ctrl.add_mode  = simd_alu_pkg::ADD_SAT;
        ctrl.is_signed = (op_i == simd_alu_pkg::OP_KADD) || (op_i == simd_alu_pkg::OP_KSUB);
        ctrl.is_sub    = (op_i == simd_alu_pkg::OP_KSUB) || (op_i == simd_alu_pkg::OP_UKSUB);
      end
      simd_alu_pkg::OP_CMPEQ,
      simd_alu_pkg::OP_SCMPLT,
      simd_alu_pkg::OP_UCMPLT: begin
        ctrl.is_sub    = 1'b1;
        ctrl.res_sel   = simd_alu_pkg::RES_CMP;
        ctrl.is_signed = (op_i == simd_alu_pkg::OP_SCMPLT);
        ctrl.cmp_kind  = (op_i == simd_alu_pkg::OP_CMPEQ) ? simd_alu_pkg::CMP_EQ
                                                          : simd_alu_pkg::CMP_LT;
      end
      simd_alu_pkg::OP_SMIN,
      simd_alu_pkg::OP_SMAX,
      simd_alu_pkg::OP_UMIN,
      simd_alu_pkg::OP_UMAX: begin
        ctrl.is_sub    = 1'b1;
        ctrl.res_sel   = simd_alu_pkg::RES_MINMAX;
        ctrl.is_signed = (op_i == simd_alu_pkg::OP_SMIN) || (op_i == simd_alu_pkg::OP_SMAX);
        ctrl.cmp_kind  = ((op_i == simd_alu_pkg::OP_SMAX) || (op_i == simd_alu_pkg::OP_UMAX))
                         ? simd_alu_pkg::CMP_MAX : simd_alu_pkg::CMP_MIN;
      end
      simd_alu_pkg::OP_SRA: begin
        ctrl.res_sel     = simd_alu_pkg::RES_SHIFT;
        ctrl.shift_arith = 1'b1;
      end
      simd_alu_pkg::OP_SRL: ctrl.res_sel = simd_alu_pkg::RES_SHIFT;
      simd_alu_pkg::OP_SLL: begin
        ctrl.res_sel    = simd_alu_pkg::RES_SHIFT;
        ctrl.shift_left = 1'b1;
      end
      default: op_legal = 1'b0;
    endcase
  end

  // Only defined op codes may be issued with valid
  op_legal_a: assert final (valid_i !== 1'b1 || op_legal)
    else $error("illegal op code %0d issued with valid", op_i);

endmodule

/* hw/simd_adder.sv */
// Lane-split adder for 8-bit and 16-bit lanes. Produces the wrapping sum,
// the per-lane extended sign used by the compare, and the wrapping,
// halving or saturating result with per-lane clamp flags.
module simd_adder (
  simd_ctrl_if.adder                 ctrl,
  input  simd_alu_pkg::word_t        operand_a_i,
  input  simd_alu_pkg::word_t        operand_b_i,
  output simd_alu_pkg::word_t        sum_o,
  output simd_alu_pkg::lane_mask_t   lane_neg_o,
  output simd_alu_pkg::word_t        result_o,
  output simd_alu_pkg::lane_mask_t   ovf_o
);

  logic                     lane16;
  logic [8:0]               byte_sum [4];
  simd_alu_pkg::lane_mask_t clamp;
  simd_alu_pkg::word_t      halve_res;
  simd_alu_pkg::word_t      sat_res;

  assign lane16 = (ctrl.lane_w == simd_alu_pkg::LANES_16);

  // 9-bit byte add; only the top byte of a lane gets the sign extension
  function automatic logic [8:0] byte_add(input logic [7:0] a, input logic [7:0] b,
                                          input logic top, input logic sgn,
                                          input logic sub, input logic cin);
    logic ext_a;
    logic ext_b;
    ext_a = top & sgn & a[7];
    ext_b = top & ((sgn & b[7]) ^ sub);
    return {ext_a, a} + {ext_b, b ^ {8{sub}}} + {8'h00, cin};
  endfunction

  ////////////////////////////////////////////////////////////
  // Byte adders
  ////////////////////////////////////////////////////////////
  always_comb begin
    for (int h = 0; h < 2; h++) begin
      byte_sum[2*h]   = byte_add(operand_a_i[16*h +: 8], operand_b_i[16*h +: 8],
                                 ~lane16, ctrl.is_signed, ctrl.is_sub, ctrl.is_sub);
      // Carry runs into the upper byte only inside a halfword lane
      byte_sum[2*h+1] = byte_add(operand_a_i[16*h+8 +: 8], operand_b_i[16*h+8 +: 8],
                                 1'b1, ctrl.is_signed, ctrl.is_sub,
                                 lane16 ? byte_sum[2*h][8] : ctrl.is_sub);
    end
  end

  ////////////////////////////////////////////////////////////
  // Halving and saturating variants
  ////////////////////////////////////////////////////////////
  always_comb begin
    logic [8:0]  hi_sum;
    logic [7:0]  sat8;
    logic [15:0] sat16;
    for (int b = 0; b < 4; b++) begin
      hi_sum        = byte_sum[lane16 ? (b | 1) : b];
      lane_neg_o[b] = hi_sum[8];
      if (ctrl.is_signed) begin
        // Sign bits of the 9-bit result disagree on overflow
        clamp[b] = hi_sum[8] ^ hi_sum[7];
        sat8     = hi_sum[8] ? simd_alu_pkg::SAT_S8_MIN  : simd_alu_pkg::SAT_S8_MAX;
        sat16    = hi_sum[8] ? simd_alu_pkg::SAT_S16_MIN : simd_alu_pkg::SAT_S16_MAX;
      end else begin
        // Carry on add, borrow on sub
        clamp[b] = hi_sum[8];
        sat8     = ctrl.is_sub ? 8'h00  : simd_alu_pkg::SAT_U8_MAX;
        sat16    = ctrl.is_sub ? 16'h00 : simd_alu_pkg::SAT_U16_MAX;
      end
      sum_o[8*b +: 8]     = byte_sum[b][7:0];
      halve_res[8*b +: 8] = (lane16 && (b % 2 == 0)) ? {byte_sum[b | 1][0], byte_sum[b][7:1]}
                                                      : byte_sum[b][8:1];
      sat_res[8*b +: 8]   = clamp[b] ? (lane16 ? sat16[8*(b % 2) +: 8] : sat8)
                                     : byte_sum[b][7:0];
    end
  end

  assign ovf_o = (ctrl.add_mode == simd_alu_pkg::ADD_SAT) ? clamp : '0;

  always_comb begin
    case (ctrl.add_mode)
      simd_alu_pkg::ADD_HALVE: result_o = halve_res;
      simd_alu_pkg::ADD_SAT:   result_o = sat_res;
      default:                 result_o = sum_o;
    endcase
  end

  // Clamp flags only leave the adder in saturating mode
  ovf_sat_only_a: assert final (ctrl.add_mode == simd_alu_pkg::ADD_SAT || ovf_o == '0)
    else $error("lane overflow flagged outside saturating mode");

endmodule

/* hw/simd_compare.sv */
// Lane compare and min/max. Works from the adder's a-b difference:
// zero difference means equal, the lane's extended sign means less-than.
module simd_compare (
  simd_ctrl_if.cmp                   ctrl,
  input  simd_alu_pkg::word_t        operand_a_i,
  input  simd_alu_pkg::word_t        operand_b_i,
  input  simd_alu_pkg::word_t        sum_i,
  input  simd_alu_pkg::lane_mask_t   lane_neg_i,
  output simd_alu_pkg::word_t        mask_o,
  output simd_alu_pkg::word_t        minmax_o
);

  logic                     lane16;
  logic [3:0]               byte_zero;
  simd_alu_pkg::lane_mask_t eq;
  simd_alu_pkg::lane_mask_t lt;

  assign lane16 = (ctrl.lane_w == simd_alu_pkg::LANES_16);

  always_comb begin
    for (int b = 0; b < 4; b++) begin
      byte_zero[b] = (sum_i[8*b +: 8] == 8'h00);
    end
  end

  always_comb begin
    int   h;
    logic a_top;
    logic b_top;
    logic pick_a;
    for (int b = 0; b < 4; b++) begin
      h     = lane16 ? (b | 1) : b;
      a_top = operand_a_i[8*h+7];
      b_top = operand_b_i[8*h+7];
      eq[b] = lane16 ? (byte_zero[b | 1] & byte_zero[b & 2]) : byte_zero[b];
      // Different top bits decide the order directly
      lt[b] = (a_top ^ b_top) ? (ctrl.is_signed ? a_top : b_top) : lane_neg_i[b];

      mask_o[8*b +: 8] = {8{(ctrl.cmp_kind == simd_alu_pkg::CMP_EQ) ? eq[b] : lt[b]}};

      // Max keeps a unless a < b
      pick_a = (ctrl.cmp_kind == simd_alu_pkg::CMP_MAX) ? ~lt[b] : lt[b];
      minmax_o[8*b +: 8] = pick_a ? operand_a_i[8*b +: 8] : operand_b_i[8*b +: 8];
    end
  end

endmodule

/* hw/simd_shifter.sv */
// Per-lane shifter. One right shift of the whole word serves all lanes;
// a thermometer mask clears bits that crossed a lane edge. Left shifts
// run on the bit-reversed operand.
module simd_shifter (
  simd_ctrl_if.shift                 ctrl,
  input  simd_alu_pkg::word_t        operand_a_i,
  input  simd_alu_pkg::word_t        operand_b_i,
  output simd_alu_pkg::word_t        result_o
);

  logic                lane16;
  logic [3:0]          amt;
  simd_alu_pkg::word_t op_rev;
  simd_alu_pkg::word_t shift_op;
  simd_alu_pkg::word_t raw;
  simd_alu_pkg::word_t mask_base;
  simd_alu_pkg::word_t lane_mask;
  simd_alu_pkg::word_t fill;
  simd_alu_pkg::word_t res_right;
  simd_alu_pkg::word_t res_rev;

  assign lane16 = (ctrl.lane_w == simd_alu_pkg::LANES_16);
  // Amount is b mod lane width
  assign amt    = lane16 ? operand_b_i[3:0] : {1'b0, operand_b_i[2:0]};

  always_comb begin
    for (int i = 0; i < simd_alu_pkg::XLEN; i++) begin
      op_rev[i]  = operand_a_i[simd_alu_pkg::XLEN-1-i];
      res_rev[i] = res_right[simd_alu_pkg::XLEN-1-i];
    end
  end

  assign shift_op = ctrl.shift_left ? op_rev : operand_a_i;
  assign raw      = shift_op >> amt;

  // Top amt bits of each lane cleared, e.g. amt=3 gives 0001_1111 per byte
  always_comb begin
    for (int i = 0; i < simd_alu_pkg::XLEN; i++) begin
      mask_base[simd_alu_pkg::XLEN-1-i] = (i >= amt);
    end
    if (lane16) begin
      lane_mask = {2{mask_base[simd_alu_pkg::XLEN-1 -: simd_alu_pkg::LANE16_W]}};
    end else begin
      lane_mask = {4{mask_base[simd_alu_pkg::XLEN-1 -: simd_alu_pkg::LANE8_W]}};
    end
  end

  // Sign fill for arithmetic shifts
  always_comb begin
    int h;
    for (int b = 0; b < 4; b++) begin
      h = lane16 ? (b | 1) : b;
      fill[8*b +: 8] = (ctrl.shift_arith && shift_op[8*h+7]) ? ~lane_mask[8*b +: 8] : 8'h00;
    end
  end

  assign res_right = (raw & lane_mask) | fill;
  assign result_o  = ctrl.shift_left ? res_rev : res_right;

endmodule

/* hw/simd_result_stage.sv */
// Output stage. Picks the unit result for the decoded op and registers
// it together with valid and the saturation flag.
module simd_result_stage (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  logic                       valid_i,
  simd_ctrl_if.result                ctrl,
  input  simd_alu_pkg::word_t        add_res_i,
  input  simd_alu_pkg::word_t        cmp_res_i,
  input  simd_alu_pkg::word_t        minmax_res_i,
  input  simd_alu_pkg::word_t        shift_res_i,
  input  simd_alu_pkg::lane_mask_t   lane_ovf_i,
  output logic                       valid_o,
  output simd_alu_pkg::word_t        result_o,
  output logic                       overflow_o
);

  simd_alu_pkg::word_t res_mux;
  logic                ovf_any;

  always_comb begin
    case (ctrl.res_sel)
      simd_alu_pkg::RES_CMP:    res_mux = cmp_res_i;
      simd_alu_pkg::RES_MINMAX: res_mux = minmax_res_i;
      simd_alu_pkg::RES_SHIFT:  res_mux = shift_res_i;
      default:                  res_mux = add_res_i;
    endcase
  end

  // Any clamped lane of a saturating op
  assign ovf_any = (|lane_ovf_i) && (ctrl.add_mode == simd_alu_pkg::ADD_SAT);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      valid_o    <= 1'b0;
      result_o   <= '0;
      overflow_o <= 1'b0;
    end else begin
      valid_o <= valid_i;
      // Result and flag hold while idle
      if (valid_i) begin
        result_o   <= res_mux;
        overflow_o <= ovf_any;
      end
    end
  end

  valid_known_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
                                   !$isunknown(valid_o))
    else $error("valid_o unknown after reset");

endmodule

/* hw/simd_alu_top.sv */
// Packed-SIMD ALU top level. One op per cycle with valid_i, result
// registered and returned with valid_o one cycle later.
module simd_alu_top (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  logic                      valid_i,
  input  simd_alu_pkg::simd_op_e    op_i,
  input  simd_alu_pkg::lane_width_e width_i,
  input  simd_alu_pkg::word_t       operand_a_i,
  input  simd_alu_pkg::word_t       operand_b_i,
  output logic                      valid_o,
  output simd_alu_pkg::word_t       result_o,
  output logic                      overflow_o
);

  simd_alu_pkg::word_t      sum;
  simd_alu_pkg::lane_mask_t lane_neg;
  simd_alu_pkg::word_t      add_res;
  simd_alu_pkg::lane_mask_t lane_ovf;
  simd_alu_pkg::word_t      cmp_res;
  simd_alu_pkg::word_t      minmax_res;
  simd_alu_pkg::word_t      shift_res;

  simd_ctrl_if ctrl_if ();

  simd_op_decoder op_decoder_i (
    .op_i     (op_i),
    .width_i  (width_i),
    .valid_i  (valid_i),
    .ctrl     (ctrl_if.dec)
  );

  simd_adder adder_i (
    .ctrl        (ctrl_if.adder),
    .operand_a_i (operand_a_i),
    .operand_b_i (operand_b_i),
    .sum_o       (sum),
    .lane_neg_o  (lane_neg),
    .result_o    (add_res),
    .ovf_o       (lane_ovf)
  );

  simd_compare compare_i (
    .ctrl        (ctrl_if.cmp),
    .operand_a_i (operand_a_i),
    .operand_b_i (operand_b_i),
    .sum_i       (sum),
    .lane_neg_i  (lane_neg),
    .mask_o      (cmp_res),
    .minmax_o    (minmax_res)
  );

  simd_shifter shifter_i (
    .ctrl        (ctrl_if.shift),
    .operand_a_i (operand_a_i),
    .operand_b_i (operand_b_i),
    .result_o    (shift_res)
  );

  simd_result_stage result_stage_i (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .valid_i      (valid_i),
    .ctrl         (ctrl_if.result),
    .add_res_i    (add_res),
    .cmp_res_i    (cmp_res),
    .minmax_res_i (minmax_res),
    .shift_res_i  (shift_res),
    .lane_ovf_i   (lane_ovf),
    .valid_o      (valid_o),
    .result_o     (result_o),
    .overflow_o   (overflow_o)
  );

endmodule

/* verification/simd_alu_ref.svh */
// Reference model for the SIMD ALU testbench. Computes the expected result
// and overflow flag of one operation lane by lane from the operation rules.
`ifndef SIMD_ALU_REF_SVH
`define SIMD_ALU_REF_SVH

// Returns {overflow, result}
function automatic logic [32:0] alu_expect(input simd_alu_pkg::simd_op_e    op,
                                           input simd_alu_pkg::lane_width_e width,
                                           input simd_alu_pkg::word_t       a,
                                           input simd_alu_pkg::word_t       b);
  int                  lw;
  int                  amt;
  int                  ua;
  int                  ub;
  int                  sa;
  int                  sb;
  int                  r;
  int                  s_hi;
  int                  s_lo;
  int                  u_max;
  logic                ovf;
  simd_alu_pkg::word_t lmask;
  simd_alu_pkg::word_t res;
  lw    = (width == simd_alu_pkg::LANES_16) ? simd_alu_pkg::LANE16_W : simd_alu_pkg::LANE8_W;
  lmask = (simd_alu_pkg::word_t'(1) << lw) - 1;
  u_max = (1 << lw) - 1;
  s_hi  = (1 << (lw - 1)) - 1;
  s_lo  = -(1 << (lw - 1));
  // One shift amount for all lanes, b mod lane width
  amt   = int'(b[3:0]) % lw;
  ovf   = 1'b0;
  res   = '0;
  for (int l = 0; l < simd_alu_pkg::XLEN / lw; l++) begin
    ua = int'((a >> (l * lw)) & lmask);
    ub = int'((b >> (l * lw)) & lmask);
    sa = (ua > s_hi) ? ua - u_max - 1 : ua;
    sb = (ub > s_hi) ? ub - u_max - 1 : ub;
    case (op)
      simd_alu_pkg::OP_ADD:    r = ua + ub;
      simd_alu_pkg::OP_SUB:    r = ua - ub;
      simd_alu_pkg::OP_RADD:   r = (sa + sb) >>> 1;
      simd_alu_pkg::OP_URADD:  r = (ua + ub) >> 1;
      simd_alu_pkg::OP_KADD,
      simd_alu_pkg::OP_KSUB: begin
        r = (op == simd_alu_pkg::OP_KADD) ? sa + sb : sa - sb;
        if (r > s_hi) begin
          r   = s_hi;
          ovf = 1'b1;
        end else if (r < s_lo) begin
          r   = s_lo;
          ovf = 1'b1;
        end
      end
      simd_alu_pkg::OP_UKADD: begin
        r = ua + ub;
        if (r > u_max) begin
          r   = u_max;
          ovf = 1'b1;
        end
      end
      simd_alu_pkg::OP_UKSUB: begin
        r = ua - ub;
        if (r < 0) begin
          r   = 0;
          ovf = 1'b1;
        end
      end
      simd_alu_pkg::OP_CMPEQ:  r = (ua == ub) ? -1 : 0;
      simd_alu_pkg::OP_SCMPLT: r = (sa < sb) ? -1 : 0;
      simd_alu_pkg::OP_UCMPLT: r = (ua < ub) ? -1 : 0;
      simd_alu_pkg::OP_SMIN:   r = (sa < sb) ? ua : ub;
      simd_alu_pkg::OP_SMAX:   r = (sa > sb) ? ua : ub;
      simd_alu_pkg::OP_UMIN:   r = (ua < ub) ? ua : ub;
      simd_alu_pkg::OP_UMAX:   r = (ua > ub) ? ua : ub;
      simd_alu_pkg::OP_SRA:    r = sa >>> amt;
      simd_alu_pkg::OP_SRL:    r = ua >> amt;
      simd_alu_pkg::OP_SLL:    r = ua << amt;
      default:                 r = 0;
    endcase
    // Keep only the lane bits, so nothing leaks into the next lane
    res = res | ((simd_alu_pkg::word_t'(r) & lmask) << (l * lw));
  end
  return {ovf, res};
endfunction

`endif

/* verification/simd_alu_tb.sv */
// Self-checking testbench for the packed-SIMD ALU. Drives directed and
// random operations, predicts each one with the reference function and
// checks every valid_o against the queue of expected values.
module simd_alu_tb;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int CLK_PERIOD      = 4;
  localparam int RESET_CYCLES    = 16;
  localparam int RAND_OPS        = 400;
  // Upper bound on the directed operations and idle gaps below
  localparam int DIRECTED_OPS    = 300;
  localparam int WATCHDOG_CYCLES = RAND_OPS + DIRECTED_OPS + 100;

  logic                      clk;
  logic                      rst_n;
  logic                      valid_in;
  simd_alu_pkg::simd_op_e    op;
  simd_alu_pkg::lane_width_e width;
  simd_alu_pkg::word_t       operand_a;
  simd_alu_pkg::word_t       operand_b;
  logic                      valid_out;
  simd_alu_pkg::word_t       result;
  logic                      overflow;

  logic [32:0] expected_q [$];
  logic        valid_prev = 1'b0;
  int          seed       = 47311;
  int          checked    = 0;

  `include "simd_alu_ref.svh"

  simd_alu_top simd_alu_top_i (
    .clk_i       (clk),
    .rst_n_i     (rst_n),
    .valid_i     (valid_in),
    .op_i        (op),
    .width_i     (width),
    .operand_a_i (operand_a),
    .operand_b_i (operand_b),
    .valid_o     (valid_out),
    .result_o    (result),
    .overflow_o  (overflow)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  ////////////////////////////////////////////////////////////
  // Failure reporting and checks
  ////////////////////////////////////////////////////////////
  task automatic abort_run();
    $display("Errors found");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic report_failure(input string why);
    $display("ERROR at %0t ns: %s", $time, why);
    abort_run();
  endtask

  task automatic check_value(input simd_alu_pkg::word_t got,
                             input simd_alu_pkg::word_t expected, input string what);
    if (got !== expected) begin
      $display("MISMATCH at %0t ns: %s is %h, expected %h", $time, what, got, expected);
      abort_run();
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Stimulus helpers, driven 1 ns after the rising edge
  ////////////////////////////////////////////////////////////
  task automatic issue_op(input simd_alu_pkg::simd_op_e op_sel,
                          input simd_alu_pkg::lane_width_e w_sel,
                          input simd_alu_pkg::word_t a, input simd_alu_pkg::word_t b);
    @(posedge clk);
    #1;
    valid_in  = 1'b1;
    op        = op_sel;
    width     = w_sel;
    operand_a = a;
    operand_b = b;
    expected_q.push_back(alu_expect(op_sel, w_sel, a, b));
  endtask

  task automatic idle_cycle();
    @(posedge clk);
    #1;
    valid_in = 1'b0;
  endtask

  // Outputs are sampled on the falling edge, half a cycle after they change
  always @(negedge clk) begin
    logic [32:0] exp_val;
    if (rst_n) begin
      if (valid_out !== valid_prev) begin
        report_failure("valid_o did not follow valid_i by exactly one cycle");
      end else if (valid_out === 1'b1) begin
        if (expected_q.size() == 0) begin
          report_failure("valid_o high with no operation outstanding");
        end else begin
          exp_val = expected_q.pop_front();
          check_value(result, exp_val[31:0], $sformatf("result_o of op %0d", checked));
          check_value(simd_alu_pkg::word_t'(overflow), simd_alu_pkg::word_t'(exp_val[32]),
                      $sformatf("overflow_o of op %0d", checked));
          checked++;
        end
      end
    end
    valid_prev = valid_in;
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    report_failure("watchdog timeout, the test did not finish in time");
  end

  ////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////
  initial begin
    simd_alu_pkg::word_t       a;
    simd_alu_pkg::word_t       b;
    simd_alu_pkg::word_t       pick;
    simd_alu_pkg::lane_width_e w;
    valid_in  = 1'b0;
    op        = simd_alu_pkg::OP_ADD;
    width     = simd_alu_pkg::LANES_8;
    operand_a = '0;
    operand_b = '0;
    rst_n     = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(negedge clk);
    check_value(simd_alu_pkg::word_t'(valid_out), '0, "valid_o after reset");
    check_value(simd_alu_pkg::word_t'(overflow), '0, "overflow_o after reset");
    check_value(result, '0, "result_o after reset");

    // Back-to-back bursts with gaps
    for (int k = 0; k < 7; k++) begin
      issue_op(simd_alu_pkg::OP_ADD, simd_alu_pkg::LANES_8, $random(seed), $random(seed));
      if (k == 3 || k == 4) idle_cycle();
    end
    idle_cycle();
    idle_cycle();

    // Wrapping and halving add/sub
    for (int k = 0; k < 12; k++) begin
      w = simd_alu_pkg::lane_width_e'(k % 2);
      for (int o = simd_alu_pkg::OP_ADD; o <= simd_alu_pkg::OP_URADD; o++) begin
        issue_op(simd_alu_pkg::simd_op_e'(o), w, $random(seed), $random(seed));
      end
    end

    // Saturation corners, one clamping lane, then no clamp at all
    issue_op(simd_alu_pkg::OP_KADD,  simd_alu_pkg::LANES_8,  32'h7f7f_7f7f, 32'h0101_0101);
    issue_op(simd_alu_pkg::OP_KSUB,  simd_alu_pkg::LANES_8,  32'h8080_8080, 32'h0101_0101);
    issue_op(simd_alu_pkg::OP_UKADD, simd_alu_pkg::LANES_16, 32'hffff_ffff, 32'h0001_0001);
    issue_op(simd_alu_pkg::OP_UKSUB, simd_alu_pkg::LANES_8,  32'h0000_0000, 32'h0101_0101);
    issue_op(simd_alu_pkg::OP_UKSUB, simd_alu_pkg::LANES_16, 32'h0000_0000, 32'h0001_0001);
    issue_op(simd_alu_pkg::OP_KADD,  simd_alu_pkg::LANES_16, 32'h7fff_7fff, 32'h0001_0001);
    issue_op(simd_alu_pkg::OP_KSUB,  simd_alu_pkg::LANES_16, 32'h8000_8000, 32'h0001_0001);
    issue_op(simd_alu_pkg::OP_UKADD, simd_alu_pkg::LANES_8,  32'hff00_7f01, 32'h0100_0101);
    issue_op(simd_alu_pkg::OP_KADD,  simd_alu_pkg::LANES_8,  32'h1020_3040, 32'h0102_0304);
    for (int k = 0; k < 16; k++) begin
      w = simd_alu_pkg::lane_width_e'(k % 2);
      for (int o = simd_alu_pkg::OP_KADD; o <= simd_alu_pkg::OP_UKSUB; o++) begin
        issue_op(simd_alu_pkg::simd_op_e'(o), w, $random(seed), $random(seed));
      end
    end

    // Compares and min/max on lane extremes and equal lanes
    for (int k = 0; k < 6; k++) begin
      w = simd_alu_pkg::lane_width_e'(k % 2);
      a = $random(seed);
      b = $random(seed);
      if (k < 2) begin
        a = 32'h807f_00ff;
        b = 32'h7f80_ff00;
      end else if (k < 4) begin
        b = a;
      end else begin
        b[31:16] = a[31:16];
      end
      for (int o = simd_alu_pkg::OP_CMPEQ; o <= simd_alu_pkg::OP_UMAX; o++) begin
        issue_op(simd_alu_pkg::simd_op_e'(o), w, a, b);
      end
    end

    // Every shift amount, upper bits of b set at random
    for (int amt = 0; amt < 16; amt++) begin
      a      = $random(seed);
      b      = $random(seed);
      b[3:0] = 4'(amt);
      for (int o = simd_alu_pkg::OP_SRA; o <= simd_alu_pkg::OP_SLL; o++) begin
        issue_op(simd_alu_pkg::simd_op_e'(o), simd_alu_pkg::LANES_16, a, b);
        issue_op(simd_alu_pkg::simd_op_e'(o), simd_alu_pkg::LANES_8, a, b);
      end
    end

    // Random mix of all ops
    for (int k = 0; k < RAND_OPS; k++) begin
      a    = $random(seed);
      b    = $random(seed);
      pick = $random(seed);
      // Copy the low half of a now and then so equal lanes turn up
      if (pick[31:30] == 2'b00) b[15:0] = a[15:0];
      issue_op(simd_alu_pkg::simd_op_e'(5'(pick[7:0] % 18)),
               simd_alu_pkg::lane_width_e'(pick[8]), a, b);
      if (k % 16 == 15) idle_cycle();
    end
    idle_cycle();

    while (expected_q.size() != 0) @(negedge clk);
    @(negedge clk);
    $display("No errors");
    $finish;
  end

endmodule

/* project.f */
+incdir+verification
hw/simd_alu_pkg.sv
hw/simd_ctrl_if.sv
hw/simd_op_decoder.sv
hw/simd_adder.sv
hw/simd_compare.sv
hw/simd_shifter.sv
hw/simd_result_stage.sv
hw/simd_alu_top.sv
verification/simd_alu_tb.sv

/* Bender.yml */
package:
  name: simd_alu

sources:
  - files:
      - hw/simd_alu_pkg.sv
      - hw/simd_ctrl_if.sv
      - hw/simd_op_decoder.sv
      - hw/simd_adder.sv
      - hw/simd_compare.sv
      - hw/simd_shifter.sv
      - hw/simd_result_stage.sv
      - hw/simd_alu_top.sv
  - target: simulation
    include_dirs:
      - verification
    files:
      - verification/simd_alu_tb.sv
